//--- design/uart_pkg.sv
package uart_pkg;

  // ======================================================================
  // Widths
  // ======================================================================

  // Serial character
  localparam int DATA_W    = 8;
  // Peripheral bus data and word address
  localparam int BUS_W     = 16;
  localparam int ADDR_W    = 14;
  // Baud divider and bit counters
  localparam int BAUD_W    = 16;
  localparam int BIT_CNT_W = 4;

  // Low address bits used for register decode
  // Two byte registers per word, even one in the low lane
  localparam int DEC_WD    = 3;

  // ======================================================================
  // Register map
  // ======================================================================

  typedef enum logic [DEC_WD-1:0] {
    CTRL    = 3'd0,
    STATUS  = 3'd1,
    BAUD_LO = 3'd2,
    BAUD_HI = 3'd3,
    DATA_TX = 3'd4,
    DATA_RX = 3'd5
  } reg_addr_e;

  // CTRL writable bits and fields
  localparam logic [DATA_W-1:0] CTRL_MASK = 8'hF1;
  localparam int IEN_TX_EMPTY = 7;
  localparam int IEN_TX       = 6;
  localparam int IEN_RX_OVFLW = 5;
  localparam int IEN_RX       = 4;
  localparam int EN           = 0;

  // STATUS fields, bit 1 reads as zero
  localparam int TX_EMPTY_PND = 7;
  localparam int TX_PND       = 6;
  localparam int RX_OVFLW_PND = 5;
  localparam int RX_PND       = 4;
  localparam int TX_FULL      = 3;
  localparam int TX_BUSY      = 2;
  localparam int RX_BUSY      = 0;

  // Bit counts that end a frame
  localparam logic [BIT_CNT_W-1:0] RX_DONE_BIT = 4'd10;
  localparam logic [BIT_CNT_W-1:0] TX_DONE_BIT = 4'd11;

endpackage

//--- design/uart_regs.sv
module uart_regs #(
  parameter logic [uart_pkg::ADDR_W:0] BASE_ADDR = 15'h0080
) (
  input  logic                        mclk,
  input  logic                        puc_rst,
  // Peripheral bus
  input  logic [uart_pkg::ADDR_W-1:0] per_addr,
  input  logic [uart_pkg::BUS_W-1:0]  per_din,
  input  logic                        per_en,
  input  logic [1:0]                  per_we,
  output logic [uart_pkg::BUS_W-1:0]  per_dout,
  // Transmitter
  input  logic                        tx_done,
  input  logic                        tx_busy,
  input  logic                        tx_full,
  output logic                        tx_load,
  output logic [uart_pkg::DATA_W-1:0] tx_data,
  // Receiver
  input  logic                        rx_done,
  input  logic [uart_pkg::DATA_W-1:0] rx_byte,
  input  logic                        rx_busy,
  // Shared config
  output logic                        ctrl_en,
  output logic [uart_pkg::BAUD_W-1:0] baud,
  // Interrupts
  output logic                        irq_uart_rx,
  output logic                        irq_uart_tx
);

  localparam int DEC_SZ = 1 << uart_pkg::DEC_WD;

  // ======================================================================
  // Address decode
  // ======================================================================

  logic                                reg_sel;
  logic                                reg_rd;
  logic [uart_pkg::DEC_WD-2:0]         reg_word;
  logic [DEC_SZ-1:0]                   wr_dec;
  logic [1:0][uart_pkg::DATA_W-1:0]    din_lane;

  // Block hit on the upper word address bits
  assign reg_sel  = per_en &
                    (per_addr[uart_pkg::ADDR_W-1:uart_pkg::DEC_WD-1] ==
                     BASE_ADDR[uart_pkg::ADDR_W:uart_pkg::DEC_WD]);
  assign reg_word = per_addr[uart_pkg::DEC_WD-2:0];
  assign reg_rd   = reg_sel & ~|per_we;
  assign din_lane = per_din;

  // One write strobe per byte register, lane from offset bit 0
  always_comb begin
    for (int i = 0; i < DEC_SZ; i++) begin
      wr_dec[i] = reg_sel & (reg_word == i[uart_pkg::DEC_WD-1:1]) & per_we[i[0]];
    end
  end

  // ======================================================================
  // Registers
  // ======================================================================

  logic [uart_pkg::DATA_W-1:0] ctrl;
  logic [uart_pkg::DATA_W-1:0] baud_lo;
  logic [uart_pkg::DATA_W-1:0] baud_hi;
  logic [uart_pkg::DATA_W-1:0] data_tx;
  logic [uart_pkg::DATA_W-1:0] data_rx;
  logic [uart_pkg::DATA_W-1:0] status_din;
  logic                        status_wr;

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      ctrl    <= '0;
      baud_lo <= '0;
      baud_hi <= '0;
      data_tx <= '0;
      data_rx <= '0;
      tx_load <= 1'b0;
    end else begin
      if (wr_dec[uart_pkg::CTRL])
        ctrl <= din_lane[uart_pkg::CTRL % 2] & uart_pkg::CTRL_MASK;
      if (wr_dec[uart_pkg::BAUD_LO])
        baud_lo <= din_lane[uart_pkg::BAUD_LO % 2];
      if (wr_dec[uart_pkg::BAUD_HI])
        baud_hi <= din_lane[uart_pkg::BAUD_HI % 2];
      if (wr_dec[uart_pkg::DATA_TX])
        data_tx <= din_lane[uart_pkg::DATA_TX % 2];
      // Received byte lands with RX_PND
      if (rx_done)
        data_rx <= rx_byte;
      // Start request follows the data write by one cycle
      tx_load <= wr_dec[uart_pkg::DATA_TX];
    end
  end

  assign ctrl_en = ctrl[uart_pkg::EN];
  assign baud    = {baud_hi, baud_lo};
  assign tx_data = data_tx;

  // Pending flags, set wins over write-one-to-clear
  logic tx_empty_pnd;
  logic tx_pnd;
  logic rx_ovflw_pnd;
  logic rx_pnd;

  assign status_wr  = wr_dec[uart_pkg::STATUS];
  assign status_din = din_lane[uart_pkg::STATUS % 2] & {uart_pkg::DATA_W{status_wr}};

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      tx_empty_pnd <= 1'b0;
      tx_pnd       <= 1'b0;
      rx_ovflw_pnd <= 1'b0;
      rx_pnd       <= 1'b0;
    end else begin
      // Empty only if nothing queued behind the finished frame
      tx_empty_pnd <= (tx_done & ~tx_full) |
                      (tx_empty_pnd & ~status_din[uart_pkg::TX_EMPTY_PND]);
      tx_pnd       <= tx_done | (tx_pnd & ~status_din[uart_pkg::TX_PND]);
      // Overflow when the previous byte was never acknowledged
      rx_ovflw_pnd <= (rx_done & rx_pnd) |
                      (rx_ovflw_pnd & ~status_din[uart_pkg::RX_OVFLW_PND]);
      rx_pnd       <= rx_done | (rx_pnd & ~status_din[uart_pkg::RX_PND]);
    end
  end

  // ======================================================================
  // Read path
  // ======================================================================

  logic [uart_pkg::DATA_W-1:0] rd_byte [DEC_SZ];

  always_comb begin
    for (int i = 0; i < DEC_SZ; i++) begin
      rd_byte[i] = '0;
    end
    rd_byte[uart_pkg::CTRL]    = ctrl;
    rd_byte[uart_pkg::STATUS][uart_pkg::TX_EMPTY_PND] = tx_empty_pnd;
    rd_byte[uart_pkg::STATUS][uart_pkg::TX_PND]       = tx_pnd;
    rd_byte[uart_pkg::STATUS][uart_pkg::RX_OVFLW_PND] = rx_ovflw_pnd;
    rd_byte[uart_pkg::STATUS][uart_pkg::RX_PND]       = rx_pnd;
    rd_byte[uart_pkg::STATUS][uart_pkg::TX_FULL]      = tx_full;
    rd_byte[uart_pkg::STATUS][uart_pkg::TX_BUSY]      = tx_busy;
    rd_byte[uart_pkg::STATUS][uart_pkg::RX_BUSY]      = rx_busy;
    rd_byte[uart_pkg::BAUD_LO] = baud_lo;
    rd_byte[uart_pkg::BAUD_HI] = baud_hi;
    rd_byte[uart_pkg::DATA_TX] = data_tx;
    rd_byte[uart_pkg::DATA_RX] = data_rx;
  end

  // Both bytes of the addressed word, zero when not reading
  assign per_dout = reg_rd ? {rd_byte[{reg_word, 1'b1}], rd_byte[{reg_word, 1'b0}]} : '0;

  // Interrupts per direction
  assign irq_uart_rx = (rx_pnd & ctrl[uart_pkg::IEN_RX]) |
                       (rx_ovflw_pnd & ctrl[uart_pkg::IEN_RX_OVFLW]);
  assign irq_uart_tx = (tx_pnd & ctrl[uart_pkg::IEN_TX]) |
                       (tx_empty_pnd & ctrl[uart_pkg::IEN_TX_EMPTY]);

endmodule

//--- design/uart_rx_filter.sv
module uart_rx_filter (
  input  logic mclk,
  input  logic puc_rst,
  input  logic uart_rxd,
  output logic rxd_s,
  output logic rxd_fall
);

  // Two-flop synchronizer, idle line is high
  logic [1:0] rxd_sync;
  // Two previous synchronized samples
  logic [1:0] rxd_hist;
  logic       rxd_maj;
  logic       rxd_maj_nxt;

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      rxd_sync <= 2'b11;
    end else begin
      rxd_sync <= {rxd_sync[0], uart_rxd};
    end
  end

  // Sample history for the filter
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      rxd_hist <= 2'b11;
    end else begin
      rxd_hist <= {rxd_hist[0], rxd_sync[1]};
    end
  end

  // Two out of three vote
  assign rxd_maj_nxt = (rxd_sync[1] & rxd_hist[0]) |
                       (rxd_sync[1] & rxd_hist[1]) |
                       (rxd_hist[0] & rxd_hist[1]);

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      rxd_maj <= 1'b1;
    end else begin
      rxd_maj <= rxd_maj_nxt;
    end
  end

  assign rxd_s    = rxd_maj;
  // High to low on the filtered line, one cycle early
  assign rxd_fall = rxd_maj & ~rxd_maj_nxt;

endmodule

//--- design/uart_rx.sv
module uart_rx (
  input  logic                        mclk,
  input  logic                        puc_rst,
  input  logic                        ctrl_en,
  input  logic [uart_pkg::BAUD_W-1:0] baud,
  input  logic                        rxd_s,
  input  logic                        rxd_fall,
  output logic                        rx_done,
  output logic [uart_pkg::DATA_W-1:0] rx_byte,
  output logic                        rx_busy
);

  logic [uart_pkg::BIT_CNT_W-1:0] bit_cnt;
  logic [uart_pkg::BAUD_W-1:0]    baud_cnt;
  logic [uart_pkg::DATA_W-1:0]    shift_buf;
  logic                           rx_start;
  logic                           bit_inc;

  // ======================================================================
  // Frame control
  // ======================================================================

  // Only an idle receiver reacts to a falling edge
  assign rx_start = (bit_cnt == '0) & rxd_fall;
  assign bit_inc  = (bit_cnt != '0) & (baud_cnt == '0);
  assign rx_done  = (bit_cnt == uart_pkg::RX_DONE_BIT);

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      bit_cnt <= '0;
    end else if (!ctrl_en) begin
      bit_cnt <= '0;
    end else if (rx_start) begin
      bit_cnt <= 4'd1;
    end else if (rx_done) begin
      bit_cnt <= '0;
    end else if (bit_inc) begin
      bit_cnt <= bit_cnt + 4'd1;
    end
  end

  // Half divider first so samples land mid-bit
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      baud_cnt <= '0;
    end else if (!ctrl_en) begin
      baud_cnt <= '0;
    end else if (rx_start) begin
      baud_cnt <= baud >> 1;
    end else if (bit_inc) begin
      baud_cnt <= baud;
    end else if (baud_cnt != '0) begin
      baud_cnt <= baud_cnt - 1'b1;
    end
  end

  // ======================================================================
  // Shift buffer
  // ======================================================================

  // LSB first, start bit falls off the bottom
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      shift_buf <= '0;
    end else if (!ctrl_en) begin
      shift_buf <= '0;
    end else if (bit_inc) begin
      shift_buf <= {rxd_s, shift_buf[uart_pkg::DATA_W-1:1]};
    end
  end

  assign rx_byte = shift_buf;
  assign rx_busy = (bit_cnt != '0);

endmodule

//--- design/uart_tx.sv
module uart_tx (
  input  logic                        mclk,
  input  logic                        puc_rst,
  input  logic                        ctrl_en,
  input  logic [uart_pkg::BAUD_W-1:0] baud,
  input  logic                        tx_load,
  input  logic [uart_pkg::DATA_W-1:0] tx_data,
  output logic                        uart_txd,
  output logic                        tx_done,
  output logic                        tx_busy,
  output logic                        tx_full
);

  logic                           tx_trig;
  logic                           tx_start;
  logic                           bit_inc;
  logic [uart_pkg::BIT_CNT_W-1:0] bit_cnt;
  logic [uart_pkg::BAUD_W-1:0]    baud_cnt;
  // Data byte plus start bit
  logic [uart_pkg::DATA_W:0]      shift_buf;

  // ======================================================================
  // Holding slot
  // ======================================================================

  // Byte waiting in DATA_TX, a new load wins over the start
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      tx_trig <= 1'b0;
    end else if (tx_load) begin
      tx_trig <= 1'b1;
    end else if (tx_start) begin
      tx_trig <= 1'b0;
    end
  end

  // ======================================================================
  // Frame control
  // ======================================================================

  assign tx_start = (bit_cnt == '0) & tx_trig;
  assign bit_inc  = (bit_cnt != '0) & (baud_cnt == '0);
  assign tx_done  = (bit_cnt == uart_pkg::TX_DONE_BIT);

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      bit_cnt <= '0;
    end else if (!ctrl_en) begin
      bit_cnt <= '0;
    end else if (tx_start) begin
      bit_cnt <= 4'd1;
    end else if (tx_done) begin
      bit_cnt <= '0;
    end else if (bit_inc) begin
      bit_cnt <= bit_cnt + 4'd1;
    end
  end

  // baud+1 cycles per serial bit
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      baud_cnt <= '0;
    end else if (!ctrl_en) begin
      baud_cnt <= '0;
    end else if (tx_start || bit_inc) begin
      baud_cnt <= baud;
    end else if (baud_cnt != '0) begin
      baud_cnt <= baud_cnt - 1'b1;
    end
  end

  // Ones shifted in from the top form the stop bit and idle
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      shift_buf <= '1;
    end else if (!ctrl_en) begin
      shift_buf <= '1;
    end else if (tx_start) begin
      shift_buf <= {tx_data, 1'b0};
    end else if (bit_inc) begin
      shift_buf <= {1'b1, shift_buf[uart_pkg::DATA_W:1]};
    end
  end

  assign uart_txd = shift_buf[0];
  assign tx_busy  = (bit_cnt != '0) | tx_trig;
  assign tx_full  = tx_busy & tx_trig;

endmodule

//--- design/uart_bb_top.sv
module uart_bb_top #(
  parameter logic [uart_pkg::ADDR_W:0] BASE_ADDR = 15'h0080
) (
  input  logic                        mclk,
  input  logic                        puc_rst,
  // Peripheral bus
  input  logic [uart_pkg::ADDR_W-1:0] per_addr,
  input  logic [uart_pkg::BUS_W-1:0]  per_din,
  input  logic                        per_en,
  input  logic [1:0]                  per_we,
  output logic [uart_pkg::BUS_W-1:0]  per_dout,
  // Serial pins
  input  logic                        uart_rxd,
  output logic                        uart_txd,
  // Interrupts
  output logic                        irq_uart_rx,
  output logic                        irq_uart_tx
);

  // Config from the register file
  logic                        ctrl_en;
  logic [uart_pkg::BAUD_W-1:0] baud;
  // Transmit side
  logic                        tx_load;
  logic [uart_pkg::DATA_W-1:0] tx_data;
  logic                        tx_done;
  logic                        tx_busy;
  logic                        tx_full;
  // Receive side
  logic                        rxd_s;
  logic                        rxd_fall;
  logic                        rx_done;
  logic [uart_pkg::DATA_W-1:0] rx_byte;
  logic                        rx_busy;

  uart_regs #(
    .BASE_ADDR (BASE_ADDR)
  ) u_regs (
    .mclk        (mclk),
    .puc_rst     (puc_rst),
    .per_addr    (per_addr),
    .per_din     (per_din),
    .per_en      (per_en),
    .per_we      (per_we),
    .per_dout    (per_dout),
    .tx_done     (tx_done),
    .tx_busy     (tx_busy),
    .tx_full     (tx_full),
    .tx_load     (tx_load),
    .tx_data     (tx_data),
    .rx_done     (rx_done),
    .rx_byte     (rx_byte),
    .rx_busy     (rx_busy),
    .ctrl_en     (ctrl_en),
    .baud        (baud),
    .irq_uart_rx (irq_uart_rx),
    .irq_uart_tx (irq_uart_tx)
  );

  // RXD cleanup ahead of the receiver
  uart_rx_filter u_rx_filter (
    .mclk     (mclk),
    .puc_rst  (puc_rst),
    .uart_rxd (uart_rxd),
    .rxd_s    (rxd_s),
    .rxd_fall (rxd_fall)
  );

  uart_rx u_rx (
    .mclk     (mclk),
    .puc_rst  (puc_rst),
    .ctrl_en  (ctrl_en),
    .baud     (baud),
    .rxd_s    (rxd_s),
    .rxd_fall (rxd_fall),
    .rx_done  (rx_done),
    .rx_byte  (rx_byte),
    .rx_busy  (rx_busy)
  );

  uart_tx u_tx (
    .mclk     (mclk),
    .puc_rst  (puc_rst),
    .ctrl_en  (ctrl_en),
    .baud     (baud),
    .tx_load  (tx_load),
    .tx_data  (tx_data),
    .uart_txd (uart_txd),
    .tx_done  (tx_done),
    .tx_busy  (tx_busy),
    .tx_full  (tx_full)
  );

endmodule

//--- verif/uart_assert.sv
module uart_assert (
  input logic                       mclk,
  input logic                       puc_rst,
  input logic                       uart_txd,
  input logic                       tx_busy,
  input logic                       rx_done,
  input logic                       per_en,
  input logic [uart_pkg::BUS_W-1:0] per_dout
);

  int fail_cnt = 0;

  // Idle transmitter holds the line high
  txd_idle_high : assert property (@(posedge mclk) disable iff (puc_rst)
    !tx_busy |-> uart_txd)
    else begin
      $error("uart_txd low while transmitter idle");
      fail_cnt++;
    end

  // Single-cycle receive strobe
  rx_done_pulse : assert property (@(posedge mclk) disable iff (puc_rst)
    rx_done |=> !rx_done)
    else begin
      $error("rx_done held longer than one cycle");
      fail_cnt++;
    end

  // Bus output parked at zero
  dout_idle_zero : assert property (@(posedge mclk) disable iff (puc_rst)
    !per_en |-> (per_dout == '0))
    else begin
      $error("per_dout nonzero without per_en");
      fail_cnt++;
    end

endmodule

bind uart_bb_top uart_assert u_assert (
  .mclk     (mclk),
  .puc_rst  (puc_rst),
  .uart_txd (uart_txd),
  .tx_busy  (tx_busy),
  .rx_done  (rx_done),
  .per_en   (per_en),
  .per_dout (per_dout)
);

//--- verif/uart_tb.sv
module uart_tb;

  localparam logic [uart_pkg::ADDR_W:0] BASE_ADDR = 15'h0080;
  localparam int CLK_PERIOD = 100;
  localparam int NUM_VEC    = 6;
  localparam int MAX_BAUD   = 15;
  // Frame allowance of 12 bit times at the slowest divider
  localparam int FRAME_CYC  = 12 * (MAX_BAUD + 1);
  localparam int WATCHDOG_T = NUM_VEC * 12 * FRAME_CYC * CLK_PERIOD + 200_000;

  logic                        mclk;
  logic                        puc_rst;
  logic [uart_pkg::ADDR_W-1:0] per_addr;
  logic [uart_pkg::BUS_W-1:0]  per_din;
  logic                        per_en;
  logic [1:0]                  per_we;
  logic [uart_pkg::BUS_W-1:0]  per_dout;
  logic                        uart_rxd;
  logic                        uart_txd;
  logic                        irq_uart_rx;
  logic                        irq_uart_tx;

  // One table row holds byte, divider and CTRL[7:4] enables
  typedef struct packed {
    logic [7:0]  data;
    logic [15:0] baud;
    logic [3:0]  ien;
  } vec_t;

  vec_t   vec_tbl [NUM_VEC];
  integer seed;
  int     errors;
  int     checks;
  int     total;

  uart_bb_top #(
    .BASE_ADDR (BASE_ADDR)
  ) UUT (
    .mclk        (mclk),
    .puc_rst     (puc_rst),
    .per_addr    (per_addr),
    .per_din     (per_din),
    .per_en      (per_en),
    .per_we      (per_we),
    .per_dout    (per_dout),
    .uart_rxd    (uart_rxd),
    .uart_txd    (uart_txd),
    .irq_uart_rx (irq_uart_rx),
    .irq_uart_tx (irq_uart_tx)
  );

  initial mclk = 1'b0;
  always #(CLK_PERIOD / 2) mclk = ~mclk;

  // ======================================================================
  // Bus access
  // ======================================================================

  // Word address of a byte register
  // Two registers share each word
  function automatic logic [uart_pkg::ADDR_W-1:0] word_addr(input logic [2:0] off);
    return BASE_ADDR[uart_pkg::ADDR_W:1] + uart_pkg::ADDR_W'(off[2:1]);
  endfunction

  // Other lane carries inverted data that must not be written
  task automatic write_reg(input logic [2:0] off, input logic [7:0] val);
    @(posedge mclk);
    per_addr <= word_addr(off);
    per_din  <= off[0] ? {val, ~val} : {~val, val};
    per_we   <= off[0] ? 2'b10 : 2'b01;
    per_en   <= 1'b1;
    @(posedge mclk);
    per_en   <= 1'b0;
    per_we   <= 2'b00;
  endtask

  // per_dout is combinational and sampled mid-cycle
  task automatic bus_read(input logic [uart_pkg::ADDR_W-1:0] addr, output logic [15:0] word);
    @(posedge mclk);
    per_addr <= addr;
    per_we   <= 2'b00;
    per_en   <= 1'b1;
    @(negedge mclk);
    word = per_dout;
    @(posedge mclk);
    per_en <= 1'b0;
  endtask

  task automatic read_reg(input logic [2:0] off, output logic [7:0] val);
    logic [15:0] word;
    bus_read(word_addr(off), word);
    val = off[0] ? word[15:8] : word[7:0];
  endtask

  task automatic compare(input string what, input logic [15:0] got, input logic [15:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("ERR %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic expect_reg(input string what, input logic [2:0] off, input logic [7:0] exp);
    logic [7:0] val;
    read_reg(off, val);
    compare(what, val, exp);
  endtask

  // Poll STATUS until all bits of mask are set
  task automatic wait_flags(input logic [7:0] mask);
    logic [7:0] st;
    int         tries;
    tries = 0;
    read_reg(uart_pkg::STATUS, st);
    while (((st & mask) != mask) && (tries < 64)) begin
      tries++;
      read_reg(uart_pkg::STATUS, st);
    end
    checks++;
    assert ((st & mask) == mask) else begin
      $display("STATUS flags 0x%02h did not come up after %0d polls", mask, tries);
      errors++;
    end
  endtask

  // ======================================================================
  // Serial side
  // ======================================================================

  // Wait for the start bit edge and sample each bit in the middle
  task automatic decode_frame(input logic [15:0] baud, output logic [7:0] data,
                              output logic start_bit, output logic stop_bit);
    @(negedge uart_txd);
    repeat (int'(baud) / 2 + 1) @(negedge mclk);
    start_bit = uart_txd;
    for (int i = 0; i < 8; i++) begin
      repeat (int'(baud) + 1) @(negedge mclk);
      data[i] = uart_txd;
    end
    repeat (int'(baud) + 1) @(negedge mclk);
    stop_bit = uart_txd;
  endtask

  // 8N1 frame sent LSB first with each bit held baud+1 cycles
  task automatic send_frame(input logic [7:0] data, input logic [15:0] baud);
    logic [9:0] frame;
    frame = {1'b1, data, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge mclk);
      uart_rxd <= frame[i];
      repeat (int'(baud)) @(posedge mclk);
    end
    @(posedge mclk);
  endtask

  task automatic end_test(input string name, input int base);
    if (errors == base)
      $display("[%0t] %s: ok", $time, name);
    else
      $display("[%0t] %s: %0d error(s)", $time, name, errors - base);
  endtask

  // ======================================================================
  // Tests
  // ======================================================================

  task automatic reset_values();
    int         base;
    logic [7:0] val;
    base = errors;
    for (int off = 0; off < 6; off++) begin
      read_reg(off[2:0], val);
      compare($sformatf("reset value of register %0d", off), val, 8'h00);
    end
    @(negedge mclk);
    compare("uart_txd after reset", uart_txd, 1'b1);
    compare("irq_uart_rx after reset", irq_uart_rx, 1'b0);
    compare("irq_uart_tx after reset", irq_uart_tx, 1'b0);
    end_test("reset values", base);
  endtask

  task automatic reg_readback();
    int          base;
    logic [15:0] word;
    base = errors;
    // Only F1 bits of CTRL stick
    write_reg(uart_pkg::CTRL, 8'hFF);
    expect_reg("CTRL", uart_pkg::CTRL, 8'hF1);
    write_reg(uart_pkg::CTRL, 8'h3E);
    expect_reg("CTRL", uart_pkg::CTRL, 8'h30);
    write_reg(uart_pkg::BAUD_LO, 8'hA5);
    write_reg(uart_pkg::BAUD_HI, 8'h3C);
    expect_reg("BAUD_LO", uart_pkg::BAUD_LO, 8'hA5);
    expect_reg("BAUD_HI", uart_pkg::BAUD_HI, 8'h3C);
    bus_read(word_addr(uart_pkg::BAUD_LO), word);
    compare("BAUD word", word, 16'h3CA5);
    write_reg(uart_pkg::CTRL, 8'h00);
    end_test("register readback", base);
  endtask

  task automatic tx_frame(input vec_t v);
    int         base;
    logic [7:0] got;
    logic       sb;
    logic       pb;
    base = errors;
    write_reg(uart_pkg::BAUD_LO, v.baud[7:0]);
    write_reg(uart_pkg::BAUD_HI, v.baud[15:8]);
    write_reg(uart_pkg::CTRL, {v.ien, 4'b0001});
    fork
      write_reg(uart_pkg::DATA_TX, v.data);
      decode_frame(v.baud, got, sb, pb);
    join
    compare("TX start bit", sb, 1'b0);
    compare("TX data", got, v.data);
    compare("TX stop bit", pb, 1'b1);
    wait_flags(8'hC0);
    expect_reg("STATUS after TX", uart_pkg::STATUS, 8'hC0);
    expect_reg("DATA_TX", uart_pkg::DATA_TX, v.data);
    @(negedge mclk);
    // TX_PND gated by IEN_TX and TX_EMPTY_PND by IEN_TX_EMPTY
    compare("irq_uart_tx", irq_uart_tx, v.ien[2] | v.ien[3]);
    write_reg(uart_pkg::STATUS, 8'hC0);
    expect_reg("STATUS after TX clear", uart_pkg::STATUS, 8'h00);
    @(negedge mclk);
    compare("irq_uart_tx after clear", irq_uart_tx, 1'b0);
    end_test($sformatf("tx byte 0x%02h baud %0d", v.data, v.baud), base);
  endtask

  task automatic rx_frame(input vec_t v);
    int base;
    base = errors;
    write_reg(uart_pkg::BAUD_LO, v.baud[7:0]);
    write_reg(uart_pkg::BAUD_HI, v.baud[15:8]);
    write_reg(uart_pkg::CTRL, {v.ien, 4'b0001});
    send_frame(v.data, v.baud);
    wait_flags(8'h10);
    expect_reg("STATUS after RX", uart_pkg::STATUS, 8'h10);
    expect_reg("DATA_RX", uart_pkg::DATA_RX, v.data);
    @(negedge mclk);
    compare("irq_uart_rx", irq_uart_rx, v.ien[0]);
    write_reg(uart_pkg::STATUS, 8'h10);
    expect_reg("STATUS after RX clear", uart_pkg::STATUS, 8'h00);
    @(negedge mclk);
    compare("irq_uart_rx after clear", irq_uart_rx, 1'b0);
    end_test($sformatf("rx byte 0x%02h baud %0d", v.data, v.baud), base);
  endtask

  task automatic rx_overflow();
    int base;
    base = errors;
    write_reg(uart_pkg::BAUD_LO, 8'd6);
    write_reg(uart_pkg::BAUD_HI, 8'd0);
    // EN and IEN_RX_OVFLW only
    write_reg(uart_pkg::CTRL, 8'h21);
    send_frame(8'h3C, 16'd6);
    send_frame(8'hC3, 16'd6);
    wait_flags(8'h30);
    expect_reg("STATUS after overflow", uart_pkg::STATUS, 8'h30);
    expect_reg("DATA_RX after overflow", uart_pkg::DATA_RX, 8'hC3);
    @(negedge mclk);
    compare("irq_uart_rx on overflow", irq_uart_rx, 1'b1);
    write_reg(uart_pkg::STATUS, 8'h30);
    expect_reg("STATUS after overflow clear", uart_pkg::STATUS, 8'h00);
    @(negedge mclk);
    compare("irq_uart_rx after overflow clear", irq_uart_rx, 1'b0);
    end_test("rx overflow", base);
  endtask

  // Leaves the UART disabled so it runs last
  task automatic disabled_uart();
    int         base;
    logic       low_seen;
    logic [7:0] st;
    base     = errors;
    low_seen = 1'b0;
    write_reg(uart_pkg::BAUD_LO, 8'd5);
    write_reg(uart_pkg::CTRL, 8'hF0);
    write_reg(uart_pkg::DATA_TX, 8'h00);
    repeat (5 + 4) @(negedge mclk) begin
      if (uart_txd !== 1'b1)
        low_seen = 1'b1;
    end
    compare("uart_txd low while disabled", low_seen, 1'b0);
    send_frame(8'h96, 16'd5);
    repeat (10) @(negedge mclk);
    read_reg(uart_pkg::STATUS, st);
    compare("pending flags while disabled", st & 8'hF0, 8'h00);
    end_test("disabled uart", base);
  endtask

  // ======================================================================
  // Main sequence
  // ======================================================================

  initial begin
    seed     = 32'h4d6c_330b;
    errors   = 0;
    checks   = 0;
    puc_rst  = 1'b1;
    per_addr = '0;
    per_din  = '0;
    per_en   = 1'b0;
    per_we   = 2'b00;
    uart_rxd = 1'b1;
    // Fixed rows first and random rows after them
    // Random dividers stay at 3 or more
    vec_tbl[0] = {8'h55, 16'd4, 4'b0100};
    vec_tbl[1] = {8'hA3, 16'd7, 4'b1001};
    vec_tbl[2] = {8'h00, 16'd10, 4'b0001};
    vec_tbl[3] = {8'hFF, 16'd15, 4'b1110};
    for (int i = 4; i < NUM_VEC; i++) begin
      vec_tbl[i].data = 8'($random(seed));
      vec_tbl[i].baud = 16'(3 + ({$random(seed)} % 13));
      vec_tbl[i].ien  = 4'($random(seed));
    end
    repeat (10) @(posedge mclk);
    puc_rst <= 1'b0;
    reset_values();
    reg_readback();
    for (int i = 0; i < NUM_VEC; i++) begin
      tx_frame(vec_tbl[i]);
      rx_frame(vec_tbl[i]);
    end
    rx_overflow();
    disabled_uart();
    total = errors + UUT.u_assert.fail_cnt;
    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, UUT.u_assert.fail_cnt);
    if (total == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_T);
    $display("Watchdog expired: tests did not finish within %0d time units", WATCHDOG_T);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

//--- sim.f
design/uart_pkg.sv
design/uart_regs.sv
design/uart_rx_filter.sv
design/uart_rx.sv
design/uart_tx.sv
design/uart_bb_top.sv
verif/uart_assert.sv
verif/uart_tb.sv

//--- Bender.yml
package:
  name: uart_bb

dependencies: {}

sources:
  - files:
      - design/uart_pkg.sv
      - design/uart_regs.sv
      - design/uart_rx_filter.sv
      - design/uart_rx.sv
      - design/uart_tx.sv
      - design/uart_bb_top.sv
  - target: test
    files:
      - verif/uart_assert.sv
      - verif/uart_tb.sv
